//--- sources.f
src/cw_ioctrl_pkg.sv
src/cw_reg_bank.sv
src/trigger_combiner.sv
src/io_router.sv
src/cw_ioctrl_top.sv
verification/cw_ioctrl_checker.sv
verification/tb_cw_ioctrl.sv

//--- src/cw_ioctrl_pkg.sv
package cw_ioctrl_pkg;

   // host register map, byte wide
   localparam logic [7:0] ADDR_TRIGSRC = 8'h27;   // trigger line mask and combine mode
   localparam logic [7:0] ADDR_TRIGMOD = 8'h28;   // trigger module select
   localparam logic [7:0] ADDR_IOROUTE = 8'h37;   // eight routing bytes, indexed by bytecnt
   localparam logic [7:0] ADDR_IOREAD  = 8'h3B;   // pin readback, read only

   // sizes
   localparam int NUM_TARGETIO      = 4;
   localparam int ROUTE_BYTES       = 8;
   localparam int BYTECNT_BITS      = 3;
   localparam int ROUTE_EXTRA_IDX   = 5;   // avr / power byte
   localparam int ROUTE_EXTGPIO_IDX = 6;   // nRST / PDID / PDIC byte
   localparam int OC_PIN_IDX        = 2;   // gpio3 is the only pin with TXO and USOC
   localparam int TRIG_LINES        = NUM_TARGETIO + 1;   // nRST plus four target IO

   // reset values
   localparam logic [7:0] TRIGSRC_RESET = 8'h20;   // io4 only, OR mode
   localparam logic [7:0] TRIGMOD_RESET = 8'h00;
   // gpio1 = TX, gpio2 = RX, the rest cleared
   localparam logic [ROUTE_BYTES*8-1:0] IOROUTE_RESET = 64'h0000_0000_0000_0201;

   // field positions inside the trigger registers
   localparam int TRIGSRC_MASK_LSB  = 1;   // bit 0 is the front panel input
   localparam int TRIGSRC_MODE_LSB  = 6;
   localparam int TRIGMOD_SEL_LSB   = 0;
   localparam int TRIGMOD_FPOUT_BIT = 3;

   // bits of the extra-gpio byte
   localparam int EXTGPIO_NRST_EN = 0;
   localparam int EXTGPIO_NRST    = 1;
   localparam int EXTGPIO_PDID_EN = 2;
   localparam int EXTGPIO_PDID    = 3;
   localparam int EXTGPIO_PDIC_EN = 4;
   localparam int EXTGPIO_PDIC    = 5;

   // combine modes, code 3 forces a low trigger
   localparam logic [1:0] COMBINE_OR   = 2'd0;
   localparam logic [1:0] COMBINE_AND  = 2'd1;
   localparam logic [1:0] COMBINE_NAND = 2'd2;

   // trigger module select
   localparam logic [2:0] TRIGMOD_EDGE    = 3'd0;
   localparam logic [2:0] TRIGMOD_ADVIO   = 3'd1;
   localparam logic [2:0] TRIGMOD_SAD     = 3'd2;
   localparam logic [2:0] TRIGMOD_DECODED = 3'd3;
   localparam logic [2:0] TRIGMOD_TRACE   = 3'd4;

   typedef struct packed {
      logic [7:0]              address;
      logic [BYTECNT_BITS-1:0] bytecnt;
      logic [7:0]              datai;
      logic                    read;
      logic                    write;
   } reg_bus_t;

   typedef struct packed {
      logic [TRIG_LINES-1:0] src_mask;   // bit 0 nRST, bits 4:1 io4..io1
      logic [1:0]            combine;
      logic [2:0]            mod_sel;
      logic                  fp_out_en;  // front panel trigger out
   } trig_cfg_t;

   // routing byte as seen by gpio1..gpio4
   typedef struct packed {
      logic en;     // drive static level
      logic lvl;
      logic usoc;   // open-collector transmit, gpio3 only
      logic txo;    // force low, gpio3 only
      logic usii;
      logic usio;
      logic rx;
      logic tx;
   } route_gpio_t;

   // same byte as seen at the extra slot
   typedef struct packed {
      logic [1:0] rsvd_hi;
      logic [1:0] smartcard;
      logic       rsvd;
      logic       fast_start;
      logic       power_off;
      logic       avr_en;
   } route_aux_t;

   typedef union packed {
      route_gpio_t gpio;
      route_aux_t  aux;
   } route_byte_u;

   typedef struct packed {
      route_byte_u [NUM_TARGETIO-1:0] gpio;
      logic                           highz;   // all pins released
   } route_cfg_t;

   typedef struct packed {
      logic [NUM_TARGETIO-1:0] out;
      logic [NUM_TARGETIO-1:0] oe;
   } pin_drive_t;

   typedef struct packed {
      logic avr_en;
      logic power_off;
      logic nrst_en;
      logic nrst;
      logic pdid_en;
      logic pdid;
      logic pdic_en;
      logic pdic;
   } aux_ctrl_t;

endpackage

//--- src/cw_ioctrl_top.sv
module cw_ioctrl_top import cw_ioctrl_pkg::*; (
   input  logic                    clk_usb,
   input  logic                    reset,
   // host register bus
   input  logic [7:0]              reg_address_i,
   input  logic [BYTECNT_BITS-1:0] reg_bytecnt_i,
   input  logic [7:0]              reg_datai_i,
   input  logic                    reg_read_i,
   input  logic                    reg_write_i,
   output logic [7:0]              reg_datao_o,
   // triggers
   input  logic [NUM_TARGETIO-1:0] trigger_io_i,
   input  logic                    trigger_nrst_i,
   input  logic                    trigger_advio_i,
   input  logic                    trigger_anapattern_i,
   input  logic                    trigger_decodedio_i,
   input  logic                    trigger_trace_i,
   output logic                    trigger_o,
   output logic                    trigger_ext_o,
   output logic                    decodeio_active_o,
   // uart and target pins
   input  logic                    uart_tx_i,
   output logic                    uart_rx_o,
   input  logic [NUM_TARGETIO-1:0] targetio_in_i,
   output logic [NUM_TARGETIO-1:0] targetio_out_o,
   output logic [NUM_TARGETIO-1:0] targetio_oe_o,
   // target side enables
   output logic                    enable_avrprog_o,
   output logic                    targetpower_off_o,
   output logic                    enable_output_nrst_o,
   output logic                    output_nrst_o,
   output logic                    enable_output_pdid_o,
   output logic                    output_pdid_o,
   output logic                    enable_output_pdic_o,
   output logic                    output_pdic_o
);

   reg_bus_t                bus;
   trig_cfg_t               trig_cfg;
   route_cfg_t              route_cfg;
   aux_ctrl_t               aux;
   pin_drive_t              drive;
   logic [NUM_TARGETIO-1:0] pin_value;

   always_comb begin
      bus.address = reg_address_i;
      bus.bytecnt = reg_bytecnt_i;
      bus.datai   = reg_datai_i;
      bus.read    = reg_read_i;
      bus.write   = reg_write_i;
   end

   // what the pad sees: our drive when enabled, else the outside world
   assign pin_value = (drive.oe & drive.out) | (~drive.oe & targetio_in_i);

   cw_reg_bank i_reg_bank (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .bus_i       (bus),
      .pin_value_i (pin_value),
      .reg_datao_o (reg_datao_o),
      .trig_cfg_o  (trig_cfg),
      .route_cfg_o (route_cfg),
      .aux_o       (aux)
   );

   trigger_combiner i_trigger_combiner (
      .cfg_i                (trig_cfg),
      .trigger_io_i         (trigger_io_i),
      .trigger_nrst_i       (trigger_nrst_i),
      .trigger_advio_i      (trigger_advio_i),
      .trigger_anapattern_i (trigger_anapattern_i),
      .trigger_decodedio_i  (trigger_decodedio_i),
      .trigger_trace_i      (trigger_trace_i),
      .trigger_o            (trigger_o),
      .trigger_ext_o        (trigger_ext_o),
      .decodeio_active_o    (decodeio_active_o)
   );

   io_router i_io_router (
      .cfg_i       (route_cfg),
      .uart_tx_i   (uart_tx_i),
      .pin_value_i (pin_value),
      .drive_o     (drive),
      .uart_rx_o   (uart_rx_o)
   );

   assign targetio_out_o = drive.out;
   assign targetio_oe_o  = drive.oe;

   // unpack target side controls
   assign enable_avrprog_o     = aux.avr_en;
   assign targetpower_off_o    = aux.power_off;
   assign enable_output_nrst_o = aux.nrst_en;
   assign output_nrst_o        = aux.nrst;
   assign enable_output_pdid_o = aux.pdid_en;
   assign output_pdid_o        = aux.pdid;
   assign enable_output_pdic_o = aux.pdic_en;
   assign output_pdic_o        = aux.pdic;

endmodule

//--- src/cw_reg_bank.sv
module cw_reg_bank import cw_ioctrl_pkg::*; (
   input  logic                    clk_usb,
   input  logic                    reset,
   input  reg_bus_t                bus_i,
   input  logic [NUM_TARGETIO-1:0] pin_value_i,   // resolved pin levels
   output logic [7:0]              reg_datao_o,
   output trig_cfg_t               trig_cfg_o,
   output route_cfg_t              route_cfg_o,
   output aux_ctrl_t               aux_o
);

   logic [7:0]                     trigsrc_q;
   logic [7:0]                     trigmod_q;
   route_byte_u [ROUTE_BYTES-1:0]  route_q;       // byte 0 at the bottom
   logic                           power_off_q;   // second stage of power off
   logic [NUM_TARGETIO-1:0]        ioread_q;
   route_byte_u                    extra_byte;
   logic [7:0]                     extgpio_byte;

   assign extra_byte   = route_q[ROUTE_EXTRA_IDX];
   assign extgpio_byte = route_q[ROUTE_EXTGPIO_IDX];

   // host writes, one strobe per byte
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_q <= TRIGSRC_RESET;
         trigmod_q <= TRIGMOD_RESET;
         route_q   <= IOROUTE_RESET;
      end else if (bus_i.write) begin
         case (bus_i.address)
            ADDR_TRIGSRC: trigsrc_q <= bus_i.datai;
            ADDR_TRIGMOD: trigmod_q <= bus_i.datai;
            ADDR_IOROUTE: route_q[bus_i.bytecnt] <= bus_i.datai;   // byte picked by bytecnt
            default: ;                                             // readback and unmapped
         endcase
      end
   end

   // power off goes through one more flop, pins tri-state with it
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         power_off_q <= 1'b0;
      end else begin
         power_off_q <= extra_byte.aux.power_off;
      end
   end

   // pin readback, one edge behind the pins
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_q <= '0;
      end else begin
         ioread_q <= pin_value_i;
      end
   end

   // read mux, zero when no read is in progress
   always_comb begin
      reg_datao_o = 8'h00;
      if (bus_i.read) begin
         case (bus_i.address)
            ADDR_TRIGSRC: reg_datao_o = trigsrc_q;
            ADDR_TRIGMOD: reg_datao_o = trigmod_q;
            ADDR_IOROUTE: reg_datao_o = route_q[bus_i.bytecnt];
            ADDR_IOREAD:  reg_datao_o = {{(8-NUM_TARGETIO){1'b0}}, ioread_q};
            default:      reg_datao_o = 8'h00;   // unmapped
         endcase
      end
   end

   // trigger config fields
   always_comb begin
      trig_cfg_o.src_mask  = trigsrc_q[TRIGSRC_MASK_LSB +: TRIG_LINES];
      trig_cfg_o.combine   = trigsrc_q[TRIGSRC_MODE_LSB +: 2];
      trig_cfg_o.mod_sel   = trigmod_q[TRIGMOD_SEL_LSB +: 3];
      trig_cfg_o.fp_out_en = trigmod_q[TRIGMOD_FPOUT_BIT];
   end

   // gpio bytes 0..3 go to the router as is
   always_comb begin
      route_cfg_o.gpio  = route_q[NUM_TARGETIO-1:0];
      route_cfg_o.highz = power_off_q;
   end

   // target side enables
   always_comb begin
      aux_o.avr_en    = extra_byte.aux.avr_en;   // follows the write directly
      aux_o.power_off = power_off_q;
      aux_o.nrst_en   = extgpio_byte[EXTGPIO_NRST_EN];
      aux_o.nrst      = extgpio_byte[EXTGPIO_NRST];
      aux_o.pdid_en   = extgpio_byte[EXTGPIO_PDID_EN];
      aux_o.pdid      = extgpio_byte[EXTGPIO_PDID];
      aux_o.pdic_en   = extgpio_byte[EXTGPIO_PDIC_EN];
      aux_o.pdic      = extgpio_byte[EXTGPIO_PDIC];
   end

endmodule

//--- src/io_router.sv
module io_router import cw_ioctrl_pkg::*; (
   input  route_cfg_t              cfg_i,
   input  logic                    uart_tx_i,
   input  logic [NUM_TARGETIO-1:0] pin_value_i,   // resolved pins from the top
   output pin_drive_t              drive_o,
   output logic                    uart_rx_o
);

   route_gpio_t g;

   // per pin drive, first matching bit wins
   always_comb begin
      drive_o.out = '0;
      drive_o.oe  = '0;
      g           = '0;
      for (int i = 0; i < NUM_TARGETIO; i++) begin
         g = cfg_i.gpio[i].gpio;
         if (cfg_i.highz) begin
            drive_o.oe[i] = 1'b0;   // power off releases everything
         end else if (g.tx) begin
            drive_o.out[i] = uart_tx_i;
            drive_o.oe[i]  = 1'b1;
         end else if ((i == OC_PIN_IDX) && g.txo) begin
            drive_o.out[i] = 1'b0;   // hard low
            drive_o.oe[i]  = 1'b1;
         end else if ((i == OC_PIN_IDX) && g.usoc) begin
            drive_o.out[i] = 1'b0;
            drive_o.oe[i]  = ~uart_tx_i;   // pull low only, released on a high bit
         end else if (g.en) begin
            drive_o.out[i] = g.lvl;   // static gpio level
            drive_o.oe[i]  = 1'b1;
         end
      end
   end

   // uart rx, lowest numbered RX pin has priority, idle high otherwise
   always_comb begin
      uart_rx_o = 1'b1;
      for (int i = NUM_TARGETIO - 1; i >= 0; i--) begin
         if (cfg_i.gpio[i].gpio.rx) begin
            uart_rx_o = pin_value_i[i];   // later hit is the lower pin
         end
      end
   end

endmodule

//--- src/trigger_combiner.sv
module trigger_combiner import cw_ioctrl_pkg::*; (
   input  trig_cfg_t               cfg_i,
   input  logic [NUM_TARGETIO-1:0] trigger_io_i,   // io4..io1
   input  logic                    trigger_nrst_i,
   input  logic                    trigger_advio_i,
   input  logic                    trigger_anapattern_i,
   input  logic                    trigger_decodedio_i,
   input  logic                    trigger_trace_i,
   output logic                    trigger_o,
   output logic                    trigger_ext_o,
   output logic                    decodeio_active_o
);

   logic [TRIG_LINES-1:0] lines;
   logic                  trig_or;
   logic                  trig_and;

   // same order as the mask, nRST in bit 0
   assign lines = {trigger_io_i, trigger_nrst_i};

   assign trig_or  = |(lines & cfg_i.src_mask);
   assign trig_and = &(lines | ~cfg_i.src_mask);   // masked lines count as true

   // combine mode
   always_comb begin
      case (cfg_i.combine)
         COMBINE_OR:   trigger_ext_o = trig_or;
         COMBINE_AND:  trigger_ext_o = trig_and;
         COMBINE_NAND: trigger_ext_o = ~trig_and;
         default:      trigger_ext_o = 1'b0;   // mode 3 holds trigger low
      endcase
   end

   // capture trigger source
   always_comb begin
      case (cfg_i.mod_sel)
         TRIGMOD_EDGE:    trigger_o = trigger_ext_o;
         TRIGMOD_ADVIO:   trigger_o = trigger_advio_i;
         TRIGMOD_SAD:     trigger_o = trigger_anapattern_i;
         TRIGMOD_DECODED: trigger_o = trigger_decodedio_i;
         TRIGMOD_TRACE:   trigger_o = trigger_trace_i;
         default:         trigger_o = 1'b0;
      endcase
   end

   assign decodeio_active_o = (cfg_i.mod_sel == TRIGMOD_DECODED);

endmodule

//--- verification/cw_ioctrl_checker.sv
module cw_ioctrl_checker import cw_ioctrl_pkg::*; (
   input  logic       clk_usb,
   input  logic       check_en_i,      // low while in reset
   input  logic [7:0] datao_i,
   input  logic [7:0] exp_datao_i,
   input  logic [2:0] trig_i,          // {trigger, trigger_ext, decodeio_active}
   input  logic [2:0] exp_trig_i,
   input  pin_drive_t drive_i,
   input  pin_drive_t exp_drive_i,
   input  logic       uart_rx_i,
   input  logic       exp_uart_rx_i,
   input  aux_ctrl_t  aux_i,
   input  aux_ctrl_t  exp_aux_i,
   output int         err_count_o
);

   int checks      = 0;
   int errors      = 0;
   int test_checks = 0;
   int test_errors = 0;
   int tests       = 0;

   assign err_count_o = errors;

   task automatic compare_val(input string what, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      test_checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // sample one time unit before the rising edge, inputs changed on the falling one
   always @(negedge clk_usb) begin
      #1;
      if (check_en_i) begin
         compare_val("reg_datao", datao_i, exp_datao_i);
         compare_val("trigger/ext/decodeio", {5'b0, trig_i}, {5'b0, exp_trig_i});
         compare_val("pin out/oe", drive_i, exp_drive_i);
         compare_val("uart_rx", {7'b0, uart_rx_i}, {7'b0, exp_uart_rx_i});
         compare_val("aux outputs", aux_i, exp_aux_i);
      end
   end

   // one line per finished test
   task automatic finish_test(input string name);
      tests++;
      $display("test %-14s %0d checks, %0d mismatches", name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic print_summary(input int timeouts);
      $display("tests %0d, checks %0d, mismatches %0d, timeouts %0d",
               tests, checks, errors, timeouts);
   endtask

endmodule

//--- verification/tb_cw_ioctrl.sv
module tb_cw_ioctrl import cw_ioctrl_pkg::*; ();

   logic            clk_usb;
   logic            reset;
   logic [7:0]      reg_address;
   logic [2:0]      reg_bytecnt;
   logic [7:0]      reg_datai;
   logic            reg_read;
   logic            reg_write;
   logic [3:0]      trig_io;
   logic            trig_nrst;
   logic            trig_advio;
   logic            trig_sad;
   logic            trig_dec;
   logic            trig_trace;
   logic            uart_tx;
   logic [3:0]      targetio_in;
   logic [7:0]      reg_datao;
   logic            trigger;
   logic            trigger_ext;
   logic            decodeio_active;
   logic            uart_rx;
   logic [3:0]      targetio_out;
   logic [3:0]      targetio_oe;
   logic [7:0]      aux_pins;      // avr, power off, nrst/pdid/pdic enable and level
   logic            check_en;
   int              err_count;
   int              timeouts;

   // shadow of the register bank
   logic [7:0]      sh_trigsrc;
   logic [7:0]      sh_trigmod;
   logic [7:0][7:0] sh_route;
   logic            sh_power_q;    // second stage of power off
   logic [3:0]      sh_ioread;

   logic [7:0]      exp_datao;
   logic [2:0]      exp_trig;
   logic            exp_ext;
   pin_drive_t      exp_drive;
   logic [3:0]      exp_pins;
   logic            exp_uart_rx;
   aux_ctrl_t       exp_aux;

   cw_ioctrl_top i_cw_ioctrl_top (
      .clk_usb(clk_usb), .reset(reset),
      .reg_address_i(reg_address), .reg_bytecnt_i(reg_bytecnt), .reg_datai_i(reg_datai),
      .reg_read_i(reg_read), .reg_write_i(reg_write), .reg_datao_o(reg_datao),
      .trigger_io_i(trig_io), .trigger_nrst_i(trig_nrst), .trigger_advio_i(trig_advio),
      .trigger_anapattern_i(trig_sad), .trigger_decodedio_i(trig_dec),
      .trigger_trace_i(trig_trace), .trigger_o(trigger), .trigger_ext_o(trigger_ext),
      .decodeio_active_o(decodeio_active), .uart_tx_i(uart_tx), .uart_rx_o(uart_rx),
      .targetio_in_i(targetio_in), .targetio_out_o(targetio_out), .targetio_oe_o(targetio_oe),
      .enable_avrprog_o(aux_pins[7]), .targetpower_off_o(aux_pins[6]),
      .enable_output_nrst_o(aux_pins[5]), .output_nrst_o(aux_pins[4]),
      .enable_output_pdid_o(aux_pins[3]), .output_pdid_o(aux_pins[2]),
      .enable_output_pdic_o(aux_pins[1]), .output_pdic_o(aux_pins[0])
   );

   cw_ioctrl_checker i_checker (
      .clk_usb(clk_usb), .check_en_i(check_en),
      .datao_i(reg_datao), .exp_datao_i(exp_datao),
      .trig_i({trigger, trigger_ext, decodeio_active}), .exp_trig_i(exp_trig),
      .drive_i({targetio_out, targetio_oe}), .exp_drive_i(exp_drive),
      .uart_rx_i(uart_rx), .exp_uart_rx_i(exp_uart_rx),
      .aux_i(aux_pins), .exp_aux_i(exp_aux), .err_count_o(err_count)
   );

   initial begin
      clk_usb = 1'b0;
      forever #2 clk_usb = ~clk_usb;
   end

   // mask bits 5:1 select nrst and io1..io4 with the mode in 7:6
   function automatic logic combine_trigger_lines(input logic [7:0] src, input logic [3:0] io,
                                                  input logic nrst);
      logic [4:0] lines;
      logic       any_hit;
      logic       all_hit;
      lines   = {io, nrst};
      any_hit = 1'b0;
      all_hit = 1'b1;   // nothing enabled counts as all true
      for (int i = 0; i < 5; i++) begin
         if (src[i+1]) begin
            any_hit = any_hit | lines[i];
            all_hit = all_hit & lines[i];
         end
      end
      case (src[7:6])
         2'd0:    return any_hit;
         2'd1:    return all_hit;
         2'd2:    return !all_hit;
         default: return 1'b0;
      endcase
   endfunction

   // srcs in module select order with edge in bit 0
   function automatic logic [2:0] select_trigger(input logic [7:0] mod, input logic [4:0] srcs);
      logic [2:0] sel;
      sel = mod[2:0];
      return {(sel <= 3'd4) ? srcs[sel] : 1'b0, srcs[0], sel == 3'd3};
   endfunction

   // gpio byte bit 7 en, 6 level, 5 usoc, 4 txo, 1 rx, 0 tx
   function automatic pin_drive_t route_pin_drive(input logic [3:0][7:0] rb, input logic highz,
                                                  input logic tx);
      pin_drive_t d;
      d = '0;
      for (int p = 0; p < 4; p++) begin
         if (!highz) begin
            if (rb[p][0]) begin
               d.out[p] = tx;
               d.oe[p]  = 1'b1;
            end else if (p == 2 && rb[p][4]) begin
               d.oe[p]  = 1'b1;   // txo holds the pin low
            end else if (p == 2 && rb[p][5]) begin
               d.oe[p]  = !tx;    // open collector pulls low only
            end else if (rb[p][7]) begin
               d.out[p] = rb[p][6];
               d.oe[p]  = 1'b1;
            end
         end
      end
      return d;
   endfunction

   function automatic logic pick_uart_rx(input logic [3:0][7:0] rb, input logic [3:0] pins);
      for (int p = 0; p < 4; p++) begin
         if (rb[p][1]) return pins[p];   // lowest rx pin wins
      end
      return 1'b1;
   endfunction

   function automatic logic [7:0] mux_read_data(input logic [7:0] addr, input logic [2:0] bcnt,
                                                input logic rd, input logic [7:0] tsrc,
                                                input logic [7:0] tmod,
                                                input logic [7:0][7:0] rt,
                                                input logic [3:0] ioread);
      if (!rd) return 8'h00;
      case (addr)
         ADDR_TRIGSRC: return tsrc;
         ADDR_TRIGMOD: return tmod;
         ADDR_IOROUTE: return rt[bcnt];
         ADDR_IOREAD:  return {4'h0, ioread};
         default:      return 8'h00;
      endcase
   endfunction

   always_comb begin
      exp_ext     = combine_trigger_lines(sh_trigsrc, trig_io, trig_nrst);
      exp_trig    = select_trigger(sh_trigmod,
                                   {trig_trace, trig_dec, trig_sad, trig_advio, exp_ext});
      exp_drive   = route_pin_drive(sh_route[3:0], sh_power_q, uart_tx);
      for (int p = 0; p < 4; p++) begin
         exp_pins[p] = exp_drive.oe[p] ? exp_drive.out[p] : targetio_in[p];   // driven or outside
      end
      exp_uart_rx = pick_uart_rx(sh_route[3:0], exp_pins);
      exp_datao   = mux_read_data(reg_address, reg_bytecnt, reg_read, sh_trigsrc, sh_trigmod,
                                  sh_route, sh_ioread);
      exp_aux     = {sh_route[5][0], sh_power_q, sh_route[6][0], sh_route[6][1],
                     sh_route[6][2], sh_route[6][3], sh_route[6][4], sh_route[6][5]};
   end

   // shadow registers track the bus on the same edge as the DUT
   always @(posedge clk_usb) begin
      if (reset) begin
         sh_trigsrc <= 8'h20;
         sh_trigmod <= 8'h00;
         sh_route   <= {48'h0, 8'h02, 8'h01};   // gpio1 tx, gpio2 rx
         sh_power_q <= 1'b0;
         sh_ioread  <= 4'h0;
      end else begin
         if (reg_write) begin
            case (reg_address)
               ADDR_TRIGSRC: sh_trigsrc <= reg_datai;
               ADDR_TRIGMOD: sh_trigmod <= reg_datai;
               ADDR_IOROUTE: sh_route[reg_bytecnt] <= reg_datai;
               default: ;
            endcase
         end
         sh_power_q <= sh_route[5][1];
         sh_ioread  <= exp_pins;
      end
   end

   task automatic write_reg(input logic [7:0] addr, input logic [2:0] bcnt,
                            input logic [7:0] data);
      @(negedge clk_usb);
      reg_address = addr;
      reg_bytecnt = bcnt;
      reg_datai   = data;
      reg_write   = 1'b1;
      @(negedge clk_usb);
      reg_write   = 1'b0;   // strobe lasts one edge
   endtask

   task automatic read_reg(input logic [7:0] addr, input logic [2:0] bcnt, input logic rd);
      @(negedge clk_usb);
      reg_address = addr;
      reg_bytecnt = bcnt;
      reg_read    = rd;
   endtask

   task automatic shake_inputs(input int cycles);
      repeat (cycles) begin
         @(negedge clk_usb);
         {trig_io, trig_nrst, trig_advio, trig_sad, trig_dec, trig_trace} = 9'($urandom);
         uart_tx     = 1'($urandom);
         targetio_in = 4'($urandom);
      end
   endtask

   // the write edge has passed when this is entered
   task automatic wait_for_oe(input logic [3:0] want, input int max_edges);
      int edges;
      edges = 1;
      while (targetio_oe !== want && edges < max_edges) begin
         @(negedge clk_usb);
         edges++;
      end
      if (targetio_oe !== want) begin
         $display("timeout: pin enables did not become %b within %0d edges of the write",
                  want, max_edges);
         timeouts++;
      end
   endtask

   initial begin
      int seed_dummy;
      seed_dummy  = $urandom(54451);
      reset       = 1'b1;
      check_en    = 1'b0;
      timeouts    = 0;
      reg_address = 8'h00;
      reg_bytecnt = 3'd0;
      reg_datai   = 8'h00;
      reg_read    = 1'b0;
      reg_write   = 1'b0;
      {trig_io, trig_nrst, trig_advio, trig_sad, trig_dec, trig_trace} = '0;
      uart_tx     = 1'b0;
      targetio_in = 4'h0;
      repeat (3) @(negedge clk_usb);
      reset    = 1'b0;
      check_en = 1'b1;

      for (int b = 0; b < 8; b++) read_reg(ADDR_IOROUTE, b[2:0], 1'b1);
      read_reg(ADDR_TRIGSRC, 3'd0, 1'b1);
      read_reg(ADDR_TRIGMOD, 3'd0, 1'b1);
      read_reg(8'h00, 3'd0, 1'b1);         // unmapped
      read_reg(8'h55, 3'd0, 1'b1);
      read_reg(ADDR_TRIGSRC, 3'd0, 1'b0);  // read low returns zero
      i_checker.finish_test("reset values");

      read_reg(ADDR_TRIGSRC, 3'd0, 1'b1);
      write_reg(ADDR_TRIGSRC, 3'd0, 8'h40);   // AND with every line masked
      shake_inputs(3);
      write_reg(ADDR_TRIGSRC, 3'd0, 8'hFE);   // mode 3
      shake_inputs(3);
      repeat (40) begin
         write_reg(ADDR_TRIGSRC, 3'd0, 8'($urandom));
         shake_inputs(4);
      end
      i_checker.finish_test("trigger combine");

      for (int s = 0; s < 8; s++) begin
         write_reg(ADDR_TRIGMOD, 3'd0, {4'($urandom), s[3:0]});
         shake_inputs(6);
      end
      i_checker.finish_test("module select");

      write_reg(ADDR_IOROUTE, 3'd2, 8'h10);   // gpio3 txo
      shake_inputs(4);
      write_reg(ADDR_IOROUTE, 3'd2, 8'h20);   // gpio3 open collector
      shake_inputs(6);
      repeat (30) begin
         for (int b = 0; b < 4; b++) write_reg(ADDR_IOROUTE, b[2:0], 8'($urandom));
         shake_inputs(4);
      end
      i_checker.finish_test("pin routing");

      for (int b = 0; b < 4; b++) write_reg(ADDR_IOROUTE, b[2:0], {1'b1, b[0], 6'h00});
      write_reg(ADDR_IOROUTE, 3'd5, 8'h02);   // power off
      wait_for_oe(4'h0, 2);
      write_reg(ADDR_IOROUTE, 3'd5, 8'h01);   // power back with avr enable
      wait_for_oe(4'hF, 2);
      repeat (8) begin
         write_reg(ADDR_IOROUTE, 3'd6, 8'($urandom));
         write_reg(ADDR_IOROUTE, 3'd5, 8'($urandom));
         shake_inputs(2);
      end
      write_reg(ADDR_IOROUTE, 3'd5, 8'h00);
      i_checker.finish_test("power and aux");

      for (int b = 0; b < 4; b++) write_reg(ADDR_IOROUTE, b[2:0], 8'h00);
      read_reg(ADDR_IOREAD, 3'd0, 1'b1);
      shake_inputs(20);
      i_checker.finish_test("pin readback");

      @(negedge clk_usb);
      i_checker.print_summary(timeouts);
      if (err_count == 0 && timeouts == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
